// File: project.f
+incdir+include
logic/icache_reg_pkg.sv
logic/icache_maint_pkg.sv
logic/icache_ack_tracker.sv
logic/icache_maint_seq.sv
logic/icache_reg_slave.sv
logic/icache_ctrl_top.sv
tests/tb_clock_gen.sv
tests/icache_ctrl_properties.sv
tests/icache_ctrl_checker.sv
tests/icache_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide from the log
rm -rf obj_dir sim.log
verilator --binary --assert --timing -f project.f --top-module icache_ctrl_tb -o icache_sim \
   && ./obj_dir/icache_sim +verilator+error+limit+100 2>&1 | tee sim.log
grep -qx "TEST OK" sim.log && exit 0 || exit 1

// File: tests/icache_ctrl_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_ctrl_config.svh"

// One cache level of one kind, answers each request bit on its own
module cache_responder #(
   parameter int unsigned N     = 8,
   parameter bit          LEVEL = 1'b0  // Ack follows the request level
) (
   input  logic         clk_i,
   input  logic         rst_ni,
   input  logic [N-1:0] req_i,
   output logic [N-1:0] ack_o
);

   localparam int unsigned MIN_DELAY = 1;
   localparam int unsigned MAX_DELAY = 6;

   logic [N-1:0] ack_q = '0;
   int unsigned  wait_cnt [N];

   always @(posedge clk_i) begin
      #2;
      for (int i = 0; i < N; i++) begin
         if (!rst_ni) begin
            ack_q[i]    = LEVEL ? req_i[i] : 1'b0;
            wait_cnt[i] = 0;
         end else if (!LEVEL && !req_i[i]) begin
            ack_q[i]    = 1'b0;  // Request gone, drop at once
            wait_cnt[i] = 0;
         end else if (ack_q[i] == req_i[i]) begin
            wait_cnt[i] = 0;
         end else if (wait_cnt[i] == 0) begin
            wait_cnt[i] = MIN_DELAY + $urandom % (MAX_DELAY - MIN_DELAY + 1);
         end else begin
            wait_cnt[i]--;
            if (wait_cnt[i] == 0) ack_q[i] = req_i[i];
         end
      end
   end

   assign ack_o = ack_q;

endmodule

module icache_ctrl_tb import icache_reg_pkg::*, icache_maint_pkg::*; ();

   localparam int unsigned NC           = `ICACHE_NB_CORES;
   localparam int unsigned NB           = `ICACHE_NB_BANKS;
   localparam int unsigned PERIOD_NS    = 40;
   localparam int unsigned RESET_CYCLES = 16;
   localparam int unsigned NUM_OPS      = 19;  // Bus accesses below
   localparam int unsigned OP_CYCLES    = 20;
   localparam int unsigned TIMEOUT_NS   = (NUM_OPS * OP_CYCLES + RESET_CYCLES) * PERIOD_NS;
   localparam logic [31:0] L1_ALL       = (32'd1 << NC) - 32'd1;
   localparam logic [31:0] L2_ALL       = (32'd1 << NB) - 32'd1;

   logic                        clk;
   logic                        rst_n;
   logic                        wb_cyc;
   logic                        wb_stb;
   logic                        wb_we;
   logic [`ICACHE_ADR_W-1:0]    wb_adr;
   logic [`ICACHE_DATA_W-1:0]   wb_dat_w;
   logic [`ICACHE_DATA_W/8-1:0] wb_sel;
   logic [`ICACHE_DATA_W-1:0]   wb_dat_r;
   logic                        wb_ack;
   l1_mask_t                    l1_bypass_req, l1_bypass_ack;
   l1_mask_t                    l1_flush_req, l1_flush_ack;
   l1_mask_t                    l1_sel_flush_req, l1_sel_flush_ack;
   l1_mask_t                    l1_prefetch_en;
   l2_mask_t                    l2_enable_req, l2_enable_ack;
   l2_mask_t                    l2_disable_req, l2_disable_ack;
   l2_mask_t                    l2_flush_req, l2_flush_ack;
   l2_mask_t                    l2_sel_flush_req, l2_sel_flush_ack;
   logic [`ICACHE_ADR_W-1:0]    l1_sel_addr;
   logic [`ICACHE_ADR_W-1:0]    l2_sel_addr;
   int unsigned                 err_count;

   tb_clock_gen u_clk (.clk_o(clk), .rst_no(rst_n));

   icache_ctrl_top dut0 (
      .clk_i (clk), .rst_ni (rst_n),
      .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat_w), .wb_sel_i (wb_sel), .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack),
      .l1_bypass_req_o (l1_bypass_req), .l1_flush_req_o (l1_flush_req),
      .l1_sel_flush_req_o (l1_sel_flush_req), .l1_sel_flush_addr_o (l1_sel_addr),
      .l1_prefetch_en_o (l1_prefetch_en), .l1_bypass_ack_i (l1_bypass_ack),
      .l1_flush_ack_i (l1_flush_ack), .l1_sel_flush_ack_i (l1_sel_flush_ack),
      .l2_enable_req_o (l2_enable_req), .l2_disable_req_o (l2_disable_req),
      .l2_flush_req_o (l2_flush_req), .l2_sel_flush_req_o (l2_sel_flush_req),
      .l2_sel_flush_addr_o (l2_sel_addr), .l2_enable_ack_i (l2_enable_ack),
      .l2_disable_ack_i (l2_disable_ack), .l2_flush_ack_i (l2_flush_ack),
      .l2_sel_flush_ack_i (l2_sel_flush_ack)
   );

   cache_responder #(.N(NC), .LEVEL(1'b1)) rsp_l1_bypass (clk, rst_n, l1_bypass_req, l1_bypass_ack);
   cache_responder #(.N(NC)) rsp_l1_flush (clk, rst_n, l1_flush_req, l1_flush_ack);
   cache_responder #(.N(NC)) rsp_l1_sel (clk, rst_n, l1_sel_flush_req, l1_sel_flush_ack);
   cache_responder #(.N(NB), .LEVEL(1'b1)) rsp_l2_en (clk, rst_n, l2_enable_req, l2_enable_ack);
   cache_responder #(.N(NB), .LEVEL(1'b1)) rsp_l2_dis (clk, rst_n, l2_disable_req, l2_disable_ack);
   cache_responder #(.N(NB)) rsp_l2_flush (clk, rst_n, l2_flush_req, l2_flush_ack);
   cache_responder #(.N(NB)) rsp_l2_sel (clk, rst_n, l2_sel_flush_req, l2_sel_flush_ack);

   icache_ctrl_checker chk0 (
      .clk_i (clk), .rst_ni (rst_n),
      .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat_w), .wb_rdata_i (wb_dat_r), .wb_ack_i (wb_ack),
      .l1_bypass_ack_i (l1_bypass_ack), .l2_enable_ack_i (l2_enable_ack),
      .l2_disable_ack_i (l2_disable_ack), .l1_flush_req_i (l1_flush_req),
      .l1_sel_flush_req_i (l1_sel_flush_req), .l2_flush_req_i (l2_flush_req),
      .l2_sel_flush_req_i (l2_sel_flush_req), .err_count_o (err_count)
   );

   // One Wishbone classic access, stb held through the ack cycle
   task automatic bus_access(input logic we, input logic [5:0] offset, input logic [31:0] data);
      @(posedge clk);
      #2;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = {24'd0, offset, 2'b00};
      wb_dat_w = data;
      @(negedge clk);
      while (!wb_ack) @(negedge clk);
      @(posedge clk);
      #2;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the bus stopped answering before all accesses were done");
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      logic [31:0] addr;
      logic [31:0] pf_data;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      wb_sel   = '1;
      void'($urandom(32'h5b8a));
      wait (rst_n === 1'b1);

      chk0.set_test("reset");
      chk0.check_value("L1 bypass requests", L1_ALL, 32'(l1_bypass_req));
      chk0.check_value("L2 enable requests", 32'd0, 32'(l2_enable_req));
      chk0.check_value("L2 disable requests", L2_ALL, 32'(l2_disable_req));
      chk0.check_value("prefetch enables", 32'd0, 32'(l1_prefetch_en));
      bus_access(1'b0, REG_ENABLE, '0);
      bus_access(1'b0, REG_PREFETCH, '0);
      bus_access(1'b0, 6'd5, '0);  // Unmapped

      chk0.set_test("enable");
      bus_access(1'b1, REG_ENABLE, 32'd1);
      chk0.check_value("L1 bypass requests", 32'd0, 32'(l1_bypass_req));
      chk0.check_value("L2 enable requests", L2_ALL, 32'(l2_enable_req));
      chk0.check_value("L2 disable requests", 32'd0, 32'(l2_disable_req));
      bus_access(1'b0, REG_ENABLE, '0);
      chk0.set_test("disable");
      bus_access(1'b1, REG_ENABLE, 32'd0);
      chk0.check_value("L1 bypass requests", L1_ALL, 32'(l1_bypass_req));
      chk0.check_value("L2 enable requests", 32'd0, 32'(l2_enable_req));
      chk0.check_value("L2 disable requests", L2_ALL, 32'(l2_disable_req));
      bus_access(1'b0, REG_ENABLE, '0);

      chk0.set_test("full flush");
      bus_access(1'b1, REG_FLUSH, 32'd1);
      chk0.check_requests('1, '1, '0, '0);
      bus_access(1'b0, REG_FLUSH, '0);
      chk0.set_test("flush with bit 0 clear");
      bus_access(1'b1, REG_FLUSH, 32'd0);
      chk0.check_requests('0, '0, '0, '0);
      chk0.set_test("flush of L1 only");
      bus_access(1'b1, REG_FLUSH_L1, 32'd1);
      chk0.check_requests('1, '0, '0, '0);

      repeat (2) begin
         addr = $urandom & 32'hFFFF_FFFC;
         chk0.set_test("selective flush");
         bus_access(1'b1, REG_SEL_FLUSH, addr);
         chk0.check_value("L1 sel-flush address", addr, l1_sel_addr);
         chk0.check_value("L2 sel-flush address", addr, l2_sel_addr);
         chk0.check_requests('0, '0, '1, '1);
         bus_access(1'b0, REG_SEL_FLUSH, '0);
         pf_data = $urandom;
         chk0.set_test("prefetch");
         bus_access(1'b1, REG_PREFETCH, pf_data);
         chk0.check_value("prefetch enables", 32'(pf_data[NC-1:0]), 32'(l1_prefetch_en));
         bus_access(1'b0, REG_PREFETCH, '0);
      end

      chk0.report(dut0.u_props.fail_count);
      if (err_count == 0 && dut0.u_props.fail_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/icache_ctrl_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_ctrl_config.svh"

module icache_ctrl_checker import icache_reg_pkg::*, icache_maint_pkg::*; (
   input  logic                      clk_i,
   input  logic                      rst_ni,
   input  logic                      wb_cyc_i,
   input  logic                      wb_stb_i,
   input  logic                      wb_we_i,
   input  logic [`ICACHE_ADR_W-1:0]  wb_adr_i,
   input  logic [`ICACHE_DATA_W-1:0] wb_dat_i,
   input  logic [`ICACHE_DATA_W-1:0] wb_rdata_i,
   input  logic                      wb_ack_i,
   input  l1_mask_t                  l1_bypass_ack_i,
   input  l2_mask_t                  l2_enable_ack_i,
   input  l2_mask_t                  l2_disable_ack_i,
   input  l1_mask_t                  l1_flush_req_i,
   input  l1_mask_t                  l1_sel_flush_req_i,
   input  l2_mask_t                  l2_flush_req_i,
   input  l2_mask_t                  l2_sel_flush_req_i,
   output int unsigned               err_count_o
);

   localparam int unsigned NC     = `ICACHE_NB_CORES;
   localparam int unsigned NB     = `ICACHE_NB_BANKS;
   localparam logic [31:0] L1_ALL = (32'd1 << NC) - 32'd1;
   localparam logic [31:0] L2_ALL = (32'd1 << NB) - 32'd1;

   string       test_name   = "none";
   int unsigned checks      = 0;
   int unsigned errors      = 0;
   logic        sh_enable   = 1'b0;  // Shadow of the register map
   logic [31:0] sh_sel_addr = '0;
   l1_mask_t    sh_prefetch = '0;
   l1_mask_t    l1_flush_seen = '0;  // Requests raised since the last look
   l2_mask_t    l2_flush_seen = '0;
   l1_mask_t    l1_sel_seen   = '0;
   l2_mask_t    l2_sel_seen   = '0;

   // Read data as the register map defines it
   function automatic logic [31:0] expected_rdata(input logic [5:0] offset, input logic en,
                                                  input logic [31:0] addr, input l1_mask_t pf);
      case (offset)
         REG_ENABLE:    return en ? ((L2_ALL << NC) | L1_ALL) : 32'd0;  // Banks above cores
         REG_FLUSH:     return 32'd0;
         REG_SEL_FLUSH: return addr;
         REG_PREFETCH:  return {{(32-NC){1'b0}}, pf};
         default:       return `ICACHE_UNMAPPED_RDATA;
      endcase
   endfunction

   task automatic set_test(input string name);
      test_name = name;
   endtask

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERROR [%s] %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_requests(input l1_mask_t l1_flush, input l2_mask_t l2_flush,
                                 input l1_mask_t l1_sel, input l2_mask_t l2_sel);
      check_value("L1 flush requests", 32'(l1_flush), 32'(l1_flush_seen));
      check_value("L2 flush requests", 32'(l2_flush), 32'(l2_flush_seen));
      check_value("L1 sel-flush requests", 32'(l1_sel), 32'(l1_sel_seen));
      check_value("L2 sel-flush requests", 32'(l2_sel), 32'(l2_sel_seen));
      l1_flush_seen = '0;
      l2_flush_seen = '0;
      l1_sel_seen   = '0;
      l2_sel_seen   = '0;
   endtask

   task automatic report(input int unsigned assert_fails);
      $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, assert_fails);
   endtask

   // Mid-cycle sampling, everything settled by now
   always @(negedge clk_i) begin : watch
      logic [5:0] offset;
      offset = wb_adr_i[REG_IDX_MSB:REG_IDX_LSB];
      if (rst_ni) begin
         l1_flush_seen |= l1_flush_req_i;
         l2_flush_seen |= l2_flush_req_i;
         l1_sel_seen   |= l1_sel_flush_req_i;
         l2_sel_seen   |= l2_sel_flush_req_i;
         if (wb_ack_i && wb_cyc_i && wb_stb_i && !wb_we_i) begin
            check_value($sformatf("read of offset %0d", offset),
                        expected_rdata(offset, sh_enable, sh_sel_addr, sh_prefetch), wb_rdata_i);
         end else if (wb_ack_i && wb_cyc_i && wb_stb_i) begin
            case (offset)
               REG_ENABLE: begin
                  sh_enable = wb_dat_i[0];
                  check_value("L1 bypass acks", wb_dat_i[0] ? 32'd0 : L1_ALL,
                              32'(l1_bypass_ack_i));
                  check_value("L2 enable or disable acks", L2_ALL,
                              wb_dat_i[0] ? 32'(l2_enable_ack_i) : 32'(l2_disable_ack_i));
               end
               REG_SEL_FLUSH: sh_sel_addr = wb_dat_i;
               REG_PREFETCH:  sh_prefetch = wb_dat_i[NC-1:0];
               default: ;
            endcase
            if (offset inside {REG_FLUSH, REG_FLUSH_L1, REG_SEL_FLUSH}) begin
               check_value("requests still high at bus ack", 32'd0,
                  32'({l1_flush_req_i, l2_flush_req_i, l1_sel_flush_req_i, l2_sel_flush_req_i}));
            end
         end
      end
   end

   assign err_count_o = errors;

endmodule

`default_nettype wire

// File: tests/icache_ctrl_properties.sv
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl_properties import icache_maint_pkg::*; (
   input logic     clk_i,
   input logic     rst_ni,
   input logic     wb_cyc_i,
   input logic     wb_stb_i,
   input logic     wb_ack_o,
   input l1_mask_t l1_flush_req_o,
   input l1_mask_t l1_flush_ack_i,
   input l1_mask_t l1_sel_flush_req_o,
   input l2_mask_t l2_flush_req_o,
   input l2_mask_t l2_flush_ack_i,
   input l2_mask_t l2_sel_flush_req_o
);

   int unsigned fail_count = 0;  // Read by the testbench top

   a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wb_ack_o |-> (wb_cyc_i && wb_stb_i))
      else begin
         $error("Bus ack raised outside a bus cycle");
         fail_count++;
      end

   // A request bit may only drop once its own ack was seen
   a_l1_flush_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (~l1_flush_req_o & $past(l1_flush_req_o) & ~$past(l1_flush_ack_i)) == '0)
      else begin
         $error("L1 flush request dropped without an ack");
         fail_count++;
      end

   a_l2_flush_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (~l2_flush_req_o & $past(l2_flush_req_o) & ~$past(l2_flush_ack_i)) == '0)
      else begin
         $error("L2 flush request dropped without an ack");
         fail_count++;
      end

   a_flush_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !((|l1_flush_req_o || |l2_flush_req_o)
        && (|l1_sel_flush_req_o || |l2_sel_flush_req_o)))
      else begin
         $error("Flush and selective flush requests high together");
         fail_count++;
      end

endmodule

bind icache_ctrl_top icache_ctrl_properties u_props (.*);

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
   output logic clk_o,
   output logic rst_no
);

   localparam int unsigned HALF_PERIOD_NS = 20;  // 40 ns clock
   localparam int unsigned RESET_CYCLES   = 16;

   initial begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
   end

   initial begin
      rst_no = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #2 rst_no = 1'b1;  // Released off the edge, like the stimulus
   end

endmodule

`default_nettype wire

// File: logic/icache_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_ctrl_config.svh"

module icache_ctrl_top import icache_maint_pkg::*; (
   input  logic                        clk_i,
   input  logic                        rst_ni,
   input  logic                        wb_cyc_i,
   input  logic                        wb_stb_i,
   input  logic                        wb_we_i,
   input  logic [`ICACHE_ADR_W-1:0]    wb_adr_i,
   input  logic [`ICACHE_DATA_W-1:0]   wb_dat_i,
   input  logic [`ICACHE_DATA_W/8-1:0] wb_sel_i,
   output logic [`ICACHE_DATA_W-1:0]   wb_dat_o,
   output logic                        wb_ack_o,
   output l1_mask_t                    l1_bypass_req_o,
   output l1_mask_t                    l1_flush_req_o,
   output l1_mask_t                    l1_sel_flush_req_o,
   output logic [`ICACHE_ADR_W-1:0]    l1_sel_flush_addr_o,
   output l1_mask_t                    l1_prefetch_en_o,
   input  l1_mask_t                    l1_bypass_ack_i,
   input  l1_mask_t                    l1_flush_ack_i,
   input  l1_mask_t                    l1_sel_flush_ack_i,
   output l2_mask_t                    l2_enable_req_o,
   output l2_mask_t                    l2_disable_req_o,
   output l2_mask_t                    l2_flush_req_o,
   output l2_mask_t                    l2_sel_flush_req_o,
   output logic [`ICACHE_ADR_W-1:0]    l2_sel_flush_addr_o,
   input  l2_mask_t                    l2_enable_ack_i,
   input  l2_mask_t                    l2_disable_ack_i,
   input  l2_mask_t                    l2_flush_ack_i,
   input  l2_mask_t                    l2_sel_flush_ack_i
);

   logic                     enable;
   logic [`ICACHE_ADR_W-1:0] sel_flush_addr;
   maint_op_t                op;
   logic                     op_start;
   logic                     op_done;
   l1_mask_t                 l1_targets;
   l2_mask_t                 l2_targets;
   logic                     trk_start;
   l1_mask_t                 l1_trk_ack;
   l2_mask_t                 l2_trk_ack;
   l1_mask_t                 l1_pending;
   l2_mask_t                 l2_pending;
   logic                     l1_done;
   logic                     l2_done;

   // Enable and disable requests are levels from the enable bit
   assign l1_bypass_req_o     = {`ICACHE_NB_CORES{~enable}};
   assign l2_enable_req_o     = {`ICACHE_NB_BANKS{enable}};
   assign l2_disable_req_o    = {`ICACHE_NB_BANKS{~enable}};
   assign l1_sel_flush_addr_o = sel_flush_addr;
   assign l2_sel_flush_addr_o = sel_flush_addr;

   icache_reg_slave u_regs (
      .clk_i, .rst_ni,
      .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_sel_i,
      .wb_dat_o, .wb_ack_o,
      .op_done_i        (op_done),
      .enable_o         (enable),
      .sel_flush_addr_o (sel_flush_addr),
      .prefetch_en_o    (l1_prefetch_en_o),
      .op_o             (op),
      .op_start_o       (op_start),
      .l1_targets_o     (l1_targets),
      .l2_targets_o     (l2_targets)
   );

   icache_maint_seq u_seq (
      .clk_i, .rst_ni,
      .op_i         (op),
      .op_start_i   (op_start),
      .l1_targets_i (l1_targets),
      .l2_targets_i (l2_targets),
      .op_done_o    (op_done),
      .l1_flush_req_o, .l1_sel_flush_req_o, .l2_flush_req_o, .l2_sel_flush_req_o,
      .l1_bypass_ack_i, .l1_flush_ack_i, .l1_sel_flush_ack_i,
      .l2_enable_ack_i, .l2_disable_ack_i, .l2_flush_ack_i, .l2_sel_flush_ack_i,
      .trk_start_o  (trk_start),
      .l1_trk_ack_o (l1_trk_ack),
      .l2_trk_ack_o (l2_trk_ack),
      .l1_pending_i (l1_pending),
      .l2_pending_i (l2_pending),
      .l1_done_i    (l1_done),
      .l2_done_i    (l2_done)
   );

   icache_ack_tracker #(.mask_t(l1_mask_t)) u_l1_track (
      .clk_i, .rst_ni,
      .start_i   (trk_start),
      .targets_i (l1_targets),
      .ack_i     (l1_trk_ack),
      .pending_o (l1_pending),
      .done_o    (l1_done)
   );

   icache_ack_tracker #(.mask_t(l2_mask_t)) u_l2_track (
      .clk_i, .rst_ni,
      .start_i   (trk_start),
      .targets_i (l2_targets),
      .ack_i     (l2_trk_ack),
      .pending_o (l2_pending),
      .done_o    (l2_done)
   );

endmodule

`default_nettype wire

// File: logic/icache_reg_slave.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_ctrl_config.svh"

module icache_reg_slave import icache_reg_pkg::*, icache_maint_pkg::*; (
   input  logic                        clk_i,
   input  logic                        rst_ni,
   input  logic                        wb_cyc_i,
   input  logic                        wb_stb_i,
   input  logic                        wb_we_i,
   input  logic [`ICACHE_ADR_W-1:0]    wb_adr_i,
   input  logic [`ICACHE_DATA_W-1:0]   wb_dat_i,
   input  logic [`ICACHE_DATA_W/8-1:0] wb_sel_i,  // Registers take whole words
   output logic [`ICACHE_DATA_W-1:0]   wb_dat_o,
   output logic                        wb_ack_o,
   input  logic                        op_done_i,
   output logic                        enable_o,
   output logic [`ICACHE_ADR_W-1:0]    sel_flush_addr_o,
   output l1_mask_t                    prefetch_en_o,
   output maint_op_t                   op_o,
   output logic                        op_start_o,
   output l1_mask_t                    l1_targets_o,
   output l2_mask_t                    l2_targets_o
);

   localparam int unsigned NC = `ICACHE_NB_CORES;
   localparam int unsigned NB = `ICACHE_NB_BANKS;
   localparam int unsigned DW = `ICACHE_DATA_W;

   reg_idx_t                 reg_idx;
   logic                     req;
   logic                     maint_wr;
   logic                     ack_q;
   logic                     busy_q;    // Maintenance operation in flight
   logic                     enable_q;
   l1_mask_t                 prefetch_q;
   logic [`ICACHE_ADR_W-1:0] sel_addr_q;
   logic [DW-1:0]            rdata;
   logic [DW-1:0]            rdata_q;

   assign reg_idx    = reg_idx_t'(wb_adr_i[REG_IDX_MSB:REG_IDX_LSB]);
   assign req        = wb_cyc_i && wb_stb_i && !ack_q && !busy_q;  // New bus cycle
   assign maint_wr   = req && wb_we_i && is_maint_reg(reg_idx);
   assign op_start_o = maint_wr;

   // Operation and its targets from offset and data
   always_comb begin
      op_o         = OP_NONE;
      l1_targets_o = '1;
      l2_targets_o = '1;
      case (reg_idx)
         REG_ENABLE: op_o = wb_dat_i[0] ? OP_ENABLE : OP_DISABLE;
         REG_FLUSH: begin
            op_o         = OP_FLUSH;
            l1_targets_o = {NC{wb_dat_i[0]}};
            l2_targets_o = {NB{wb_dat_i[0]}};
         end
         REG_FLUSH_L1: begin
            op_o         = OP_FLUSH;
            l2_targets_o = '0;  // L2 banks untouched
         end
         REG_SEL_FLUSH: op_o = OP_SEL_FLUSH;
         default: begin
            l1_targets_o = '0;
            l2_targets_o = '0;
         end
      endcase
   end

   always_comb begin
      case (reg_idx)
         REG_ENABLE:    rdata = {{(DW-NB-NC){1'b0}}, {(NB+NC){enable_q}}};
         REG_FLUSH:     rdata = '0;  // Always clear between operations
         REG_SEL_FLUSH: rdata = sel_addr_q;
         REG_PREFETCH:  rdata = {{(DW-NC){1'b0}}, prefetch_q};
         default:       rdata = `ICACHE_UNMAPPED_RDATA;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         ack_q      <= 1'b0;
         busy_q     <= 1'b0;
         enable_q   <= 1'b0;  // Caches start in bypass
         prefetch_q <= '0;
      end else begin
         ack_q <= (req && !maint_wr) || op_done_i;
         if (maint_wr) begin
            busy_q <= 1'b1;
         end else if (op_done_i) begin
            busy_q <= 1'b0;
         end
         if (req && wb_we_i && reg_idx == REG_ENABLE) enable_q <= wb_dat_i[0];
         if (req && wb_we_i && reg_idx == REG_PREFETCH) prefetch_q <= wb_dat_i[NC-1:0];
      end
   end

   always_ff @(posedge clk_i) begin
      if (req && wb_we_i && reg_idx == REG_SEL_FLUSH) sel_addr_q <= wb_dat_i;
      if (req && !wb_we_i) rdata_q <= rdata;  // Valid with the ack
   end

   assign wb_ack_o         = ack_q;
   assign wb_dat_o         = rdata_q;
   assign enable_o         = enable_q;
   assign sel_flush_addr_o = sel_addr_q;
   assign prefetch_en_o    = prefetch_q;

endmodule

`default_nettype wire

// File: logic/icache_maint_seq.sv
`timescale 1ns/100ps
`default_nettype none

module icache_maint_seq import icache_maint_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_ni,
   input  maint_op_t op_i,
   input  logic      op_start_i,
   input  l1_mask_t  l1_targets_i,
   input  l2_mask_t  l2_targets_i,
   output logic      op_done_o,
   output l1_mask_t  l1_flush_req_o,
   output l1_mask_t  l1_sel_flush_req_o,
   output l2_mask_t  l2_flush_req_o,
   output l2_mask_t  l2_sel_flush_req_o,
   input  l1_mask_t  l1_bypass_ack_i,
   input  l1_mask_t  l1_flush_ack_i,
   input  l1_mask_t  l1_sel_flush_ack_i,
   input  l2_mask_t  l2_enable_ack_i,
   input  l2_mask_t  l2_disable_ack_i,
   input  l2_mask_t  l2_flush_ack_i,
   input  l2_mask_t  l2_sel_flush_ack_i,
   output logic      trk_start_o,
   output l1_mask_t  l1_trk_ack_o,
   output l2_mask_t  l2_trk_ack_o,
   input  l1_mask_t  l1_pending_i,
   input  l2_mask_t  l2_pending_i,
   input  logic      l1_done_i,
   input  logic      l2_done_i
);

   typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_DONE} state_t;

   state_t    state_q;
   state_t    state_d;
   maint_op_t op_q;
   l1_mask_t  l1_tgt_q;
   l2_mask_t  l2_tgt_q;
   logic      l1_seen_q;  // Level finished earlier in this operation
   logic      l2_seen_q;
   logic      all_done;

   assign trk_start_o = op_start_i && (state_q == ST_IDLE);
   assign all_done    = (state_q == ST_BUSY) && (l1_seen_q || l1_done_i)
                        && (l2_seen_q || l2_done_i);
   assign op_done_o   = all_done;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (trk_start_o) state_d = ST_BUSY;
         end
         ST_BUSY: begin
            if (all_done) state_d = ST_DONE;
         end
         default: state_d = ST_IDLE;  // DONE spans the bus ack cycle
      endcase
   end

   // Ack vector of the running operation into each tracker
   always_comb begin
      case (op_q)
         OP_ENABLE: begin
            l1_trk_ack_o = ~l1_bypass_ack_i;  // Bypass ack low means enabled
            l2_trk_ack_o = l2_enable_ack_i;
         end
         OP_DISABLE: begin
            l1_trk_ack_o = l1_bypass_ack_i;
            l2_trk_ack_o = l2_disable_ack_i;
         end
         OP_FLUSH: begin
            l1_trk_ack_o = l1_flush_ack_i;
            l2_trk_ack_o = l2_flush_ack_i;
         end
         OP_SEL_FLUSH: begin
            l1_trk_ack_o = l1_sel_flush_ack_i;
            l2_trk_ack_o = l2_sel_flush_ack_i;
         end
         default: begin
            l1_trk_ack_o = '0;
            l2_trk_ack_o = '0;
         end
      endcase
   end

   // Requests stay up while the target is still pending
   always_comb begin
      l1_flush_req_o     = '0;
      l2_flush_req_o     = '0;
      l1_sel_flush_req_o = '0;
      l2_sel_flush_req_o = '0;
      if (state_q == ST_BUSY && op_q == OP_FLUSH) begin
         l1_flush_req_o = l1_pending_i & l1_tgt_q;
         l2_flush_req_o = l2_pending_i & l2_tgt_q;
      end
      if (state_q == ST_BUSY && op_q == OP_SEL_FLUSH) begin
         l1_sel_flush_req_o = l1_pending_i & l1_tgt_q;
         l2_sel_flush_req_o = l2_pending_i & l2_tgt_q;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q   <= ST_IDLE;
         op_q      <= OP_NONE;
         l1_seen_q <= 1'b0;
         l2_seen_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (trk_start_o) begin
            op_q      <= op_i;
            l1_seen_q <= 1'b0;
            l2_seen_q <= 1'b0;
         end else begin
            l1_seen_q <= l1_seen_q | l1_done_i;
            l2_seen_q <= l2_seen_q | l2_done_i;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (trk_start_o) begin
         l1_tgt_q <= l1_targets_i;
         l2_tgt_q <= l2_targets_i;
      end
   end

endmodule

`default_nettype wire

// File: logic/icache_ack_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module icache_ack_tracker #(
   parameter type mask_t = logic [7:0]
) (
   input  logic  clk_i,
   input  logic  rst_ni,
   input  logic  start_i,
   input  mask_t targets_i,
   input  mask_t ack_i,
   output mask_t pending_o,
   output logic  done_o
);

   mask_t pending_q;  // Caches that still owe an ack
   logic  active_q;
   logic  done_q;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         pending_q <= '0;
         active_q  <= 1'b0;
         done_q    <= 1'b0;
      end else begin
         done_q <= 1'b0;  // Single cycle pulse
         if (start_i) begin
            pending_q <= targets_i;
            active_q  <= |targets_i;
            done_q    <= ~|targets_i;  // Nothing to wait for
         end else if (active_q && pending_q == '0) begin
            active_q <= 1'b0;
            done_q   <= 1'b1;
         end else begin
            pending_q <= pending_q & ~ack_i;  // Retire answered caches
         end
      end
   end

   assign pending_o = pending_q;
   assign done_o    = done_q;

endmodule

`default_nettype wire

// File: logic/icache_maint_pkg.sv
`default_nettype none

`include "icache_ctrl_config.svh"

package icache_maint_pkg;

   typedef enum logic [2:0] {
      OP_NONE,
      OP_ENABLE,     // Leave bypass, enable L2 banks
      OP_DISABLE,    // Back to bypass, disable L2 banks
      OP_FLUSH,      // Flush request per target
      OP_SEL_FLUSH   // Selective flush at the stored address
   } maint_op_t;

   // Target masks, one bit per cache
   typedef logic [`ICACHE_NB_CORES-1:0] l1_mask_t;
   typedef logic [`ICACHE_NB_BANKS-1:0] l2_mask_t;

endpackage

`default_nettype wire

// File: logic/icache_reg_pkg.sv
`default_nettype none

package icache_reg_pkg;

   // Word offset sits in address bits 7 to 2
   localparam int unsigned REG_IDX_LSB = 2;
   localparam int unsigned REG_IDX_MSB = 7;
   localparam int unsigned REG_IDX_W   = REG_IDX_MSB - REG_IDX_LSB + 1;

   typedef enum logic [REG_IDX_W-1:0] {
      REG_ENABLE    = 6'd0,  // Global enable, write starts enable or disable
      REG_FLUSH     = 6'd1,  // Full flush when bit 0 set
      REG_FLUSH_L1  = 6'd2,  // Flush of the L1 caches only
      REG_SEL_FLUSH = 6'd3,  // Selective flush by address
      REG_PREFETCH  = 6'd7   // L1 to L1.5 prefetch, one bit per core
   } reg_idx_t;

   // Offsets whose write starts a maintenance operation
   function automatic logic is_maint_reg(reg_idx_t idx);
      return idx inside {REG_ENABLE, REG_FLUSH, REG_FLUSH_L1, REG_SEL_FLUSH};
   endfunction

endpackage

`default_nettype wire

// File: include/icache_ctrl_config.svh
`ifndef ICACHE_CTRL_CONFIG_SVH
`define ICACHE_CTRL_CONFIG_SVH

// Cache topology
`define ICACHE_NB_CORES 8   // L1 caches, one per core
`define ICACHE_NB_BANKS 4   // L2 banks

// Wishbone widths
`define ICACHE_DATA_W 32
`define ICACHE_ADR_W  32

// Read value for offsets with no register behind them
`define ICACHE_UNMAPPED_RDATA 32'hDEAD_CA5E

`endif
